// ==== pipe_pkg.sv ====
// ex/mem pipeline shared types
package pipe_pkg;

  // data path widths
  localparam int WORD_WD     = 64;
  localparam int ADDR_WD     = 32;
  localparam int WMASK_WD    = 8;
  localparam int GPR_ADDR_WD = 5;

  // data sram geometry
  localparam int SRAM_DEPTH   = 256;
  localparam int SRAM_IDX_WD  = 8;
  localparam int SRAM_IDX_LSB = 3;   // word aligned index, addr[10:3]

  typedef logic [WORD_WD-1:0]     word_t;
  typedef logic [ADDR_WD-1:0]     addr_t;
  typedef logic [WMASK_WD-1:0]    wmask_t;
  typedef logic [GPR_ADDR_WD-1:0] gpr_addr_t;

  typedef enum logic [3:0] {
    alu_add   = 4'd0,
    alu_sub   = 4'd1,
    alu_sll   = 4'd2,
    alu_srl   = 4'd3,
    alu_sra   = 4'd4,
    alu_slt   = 4'd5,
    alu_sltu  = 4'd6,
    alu_and   = 4'd7,
    alu_or    = 4'd8,
    alu_xor   = 4'd9,
    alu_pass2 = 4'd10   // lui style, src2 straight through
  } alu_op_t;

  // same coding as the load/store funct3 field
  // stores look only at the low two bits
  typedef enum logic [2:0] {
    mem_b  = 3'b000,
    mem_h  = 3'b001,
    mem_w  = 3'b010,
    mem_d  = 3'b011,
    mem_bu = 3'b100,
    mem_hu = 3'b101,
    mem_wu = 3'b110
  } mem_op_t;

endpackage

// ==== ex_alu.sv ====
// execute stage alu
module ex_alu (
  input  pipe_pkg::alu_op_t i_op,
  input  logic              i_word_cut,
  input  pipe_pkg::word_t   i_src1,
  input  pipe_pkg::word_t   i_src2,
  output pipe_pkg::word_t   o_result
);
  import pipe_pkg::*;

  logic [5:0] shamt;
  word_t      srl_src;   // zero extended low word in word mode
  word_t      sra_src;   // sign extended low word in word mode
  word_t      raw;

  always_comb begin
    if (i_word_cut) begin
      shamt   = {1'b0, i_src2[4:0]};
      srl_src = {32'b0, i_src1[31:0]};
      sra_src = {{32{i_src1[31]}}, i_src1[31:0]};
    end else begin
      shamt   = i_src2[5:0];
      srl_src = i_src1;
      sra_src = i_src1;
    end
  end

  always_comb begin
    unique case (i_op)
      alu_add:   raw = i_src1 + i_src2;
      alu_sub:   raw = i_src1 - i_src2;
      alu_sll:   raw = i_src1 << shamt;
      alu_srl:   raw = srl_src >> shamt;
      alu_sra:   raw = $signed(sra_src) >>> shamt;
      alu_slt:   raw = {63'b0, $signed(i_src1) < $signed(i_src2)};
      alu_sltu:  raw = {63'b0, i_src1 < i_src2};
      alu_and:   raw = i_src1 & i_src2;
      alu_or:    raw = i_src1 | i_src2;
      alu_xor:   raw = i_src1 ^ i_src2;
      alu_pass2: raw = i_src2;
      default:   raw = '0;
    endcase
  end

  // *w ops keep the low word, sign extended
  assign o_result = i_word_cut ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

// ==== ex_store_align.sv ====
// store byte lane alignment
module ex_store_align (
  input  pipe_pkg::mem_op_t i_mem_op,
  input  logic [2:0]        i_offset,
  input  pipe_pkg::word_t   i_data,
  output pipe_pkg::wmask_t  o_wmask,
  output pipe_pkg::word_t   o_wdata
);
  import pipe_pkg::*;

  wmask_t base_mask;

  // only the size matters for a store
  always_comb begin
    unique case (i_mem_op)
      mem_b, mem_bu: base_mask = 8'h01;
      mem_h, mem_hu: base_mask = 8'h03;
      mem_w, mem_wu: base_mask = 8'h0f;
      default:       base_mask = 8'hff;
    endcase
  end

  // naturally aligned, so the mask never wraps past lane 7
  assign o_wmask = base_mask << i_offset;
  assign o_wdata = i_data << {i_offset, 3'b000};

endmodule

// ==== ex_stage.sv ====
// execute stage
module ex_stage (
  input  logic                i_clk,
  input  logic                i_reset,
  // issue side
  input  logic                i_issue_valid,
  output logic                o_issue_allowin,
  input  pipe_pkg::alu_op_t   i_issue_op,
  input  logic                i_issue_word_cut,
  input  pipe_pkg::word_t     i_issue_src1,
  input  pipe_pkg::word_t     i_issue_src2,
  input  pipe_pkg::word_t     i_issue_store_data,
  input  pipe_pkg::gpr_addr_t i_issue_rd,
  input  logic                i_issue_gpr_wen,
  input  logic                i_issue_mem_ren,
  input  logic                i_issue_mem_wen,
  input  pipe_pkg::mem_op_t   i_issue_mem_op,
  // to ms
  input  logic                i_ms_allowin,
  output logic                o_es_to_ms_valid,
  output pipe_pkg::gpr_addr_t o_ms_rd,
  output logic                o_ms_gpr_wen,
  output logic                o_ms_mem_ren,
  output pipe_pkg::mem_op_t   o_ms_mem_op,
  output pipe_pkg::word_t     o_ms_alu_result,
  // data sram request
  output pipe_pkg::addr_t     o_sram_addr,
  output logic                o_sram_ren,
  output logic                o_sram_wen,
  output pipe_pkg::wmask_t    o_sram_wmask,
  output pipe_pkg::word_t     o_sram_wdata,
  input  logic                i_sram_addr_ok
);
  import pipe_pkg::*;

  logic      es_valid;
  logic      es_ready_go;
  alu_op_t   es_op;
  logic      es_word_cut;
  word_t     es_src1;
  word_t     es_src2;
  word_t     es_store_data;
  gpr_addr_t es_rd;
  logic      es_gpr_wen;
  logic      es_mem_ren;
  logic      es_mem_wen;
  mem_op_t   es_mem_op;
  word_t     es_alu_result;

  // memory ops leave only once the sram took the address
  assign es_ready_go      = (es_mem_ren || es_mem_wen) ? i_sram_addr_ok : 1'b1;
  assign o_issue_allowin  = !es_valid || (es_ready_go && i_ms_allowin);
  assign o_es_to_ms_valid = es_valid && es_ready_go;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      es_valid <= 1'b0;
    end else if (o_issue_allowin) begin
      es_valid <= i_issue_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_issue_valid && o_issue_allowin) begin
      es_op         <= i_issue_op;
      es_word_cut   <= i_issue_word_cut;
      es_src1       <= i_issue_src1;
      es_src2       <= i_issue_src2;
      es_store_data <= i_issue_store_data;
      es_rd         <= i_issue_rd;
      es_gpr_wen    <= i_issue_gpr_wen;
      es_mem_ren    <= i_issue_mem_ren;
      es_mem_wen    <= i_issue_mem_wen;
      es_mem_op     <= i_issue_mem_op;
    end
  end

  ex_alu u_ex_alu (
    .i_op       (es_op),
    .i_word_cut (es_word_cut),
    .i_src1     (es_src1),
    .i_src2     (es_src2),
    .o_result   (es_alu_result)
  );

  ex_store_align u_ex_store_align (
    .i_mem_op (es_mem_op),
    .i_offset (es_alu_result[2:0]),   // rs1 + imm
    .i_data   (es_store_data),
    .o_wmask  (o_sram_wmask),
    .o_wdata  (o_sram_wdata)
  );

  // read data comes back in ms, so only ask when ms can take the load
  assign o_sram_ren  = es_valid && es_mem_ren && i_ms_allowin;
  assign o_sram_wen  = es_valid && es_mem_wen;
  assign o_sram_addr = es_alu_result[ADDR_WD-1:0];

  assign o_ms_rd         = es_rd;
  assign o_ms_gpr_wen    = es_gpr_wen;
  assign o_ms_mem_ren    = es_mem_ren;
  assign o_ms_mem_op     = es_mem_op;
  assign o_ms_alu_result = es_alu_result;

endmodule

// ==== mem_stage.sv ====
// memory stage
module mem_stage (
  input  logic                i_clk,
  input  logic                i_reset,
  // from es
  input  logic                i_es_to_ms_valid,
  output logic                o_ms_allowin,
  input  pipe_pkg::gpr_addr_t i_ms_rd,
  input  logic                i_ms_gpr_wen,
  input  logic                i_ms_mem_ren,
  input  pipe_pkg::mem_op_t   i_ms_mem_op,
  input  pipe_pkg::word_t     i_ms_alu_result,
  // load data from sram
  input  pipe_pkg::word_t     i_sram_rdata,
  // write back
  input  logic                i_wb_allowin,
  output logic                o_wb_valid,
  output pipe_pkg::gpr_addr_t o_wb_rd,
  output logic                o_wb_gpr_wen,
  output pipe_pkg::word_t     o_wb_data
);
  import pipe_pkg::*;

  logic       ms_valid;
  gpr_addr_t  ms_rd;
  logic       ms_gpr_wen;
  logic       ms_mem_ren;
  mem_op_t    ms_mem_op;
  word_t      ms_alu_result;
  logic [2:0] ms_offset;
  word_t      ld_shift;
  word_t      ld_data;

  assign o_ms_allowin = !ms_valid || i_wb_allowin;   // empty or draining

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ms_valid <= 1'b0;
    end else if (o_ms_allowin) begin
      ms_valid <= i_es_to_ms_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_es_to_ms_valid && o_ms_allowin) begin
      ms_rd         <= i_ms_rd;
      ms_gpr_wen    <= i_ms_gpr_wen;
      ms_mem_ren    <= i_ms_mem_ren;
      ms_mem_op     <= i_ms_mem_op;
      ms_alu_result <= i_ms_alu_result;
    end
  end

  // byte offset inside the 64-bit word
  assign ms_offset = ms_alu_result[2:0];
  assign ld_shift  = i_sram_rdata >> {ms_offset, 3'b000};

  always_comb begin
    unique case (ms_mem_op)
      mem_b:   ld_data = {{56{ld_shift[7]}}, ld_shift[7:0]};
      mem_h:   ld_data = {{48{ld_shift[15]}}, ld_shift[15:0]};
      mem_w:   ld_data = {{32{ld_shift[31]}}, ld_shift[31:0]};
      mem_bu:  ld_data = {56'b0, ld_shift[7:0]};
      mem_hu:  ld_data = {48'b0, ld_shift[15:0]};
      mem_wu:  ld_data = {32'b0, ld_shift[31:0]};
      default: ld_data = ld_shift;   // ld
    endcase
  end

  assign o_wb_valid   = ms_valid;
  assign o_wb_rd      = ms_rd;
  assign o_wb_gpr_wen = ms_gpr_wen;
  assign o_wb_data    = ms_mem_ren ? ld_data : ms_alu_result;

endmodule

// ==== data_sram.sv ====
// on-chip data memory
module data_sram (
  input  logic             i_clk,
  input  logic             i_reset,
  input  pipe_pkg::addr_t  i_addr,
  input  logic             i_ren,
  input  logic             i_wen,
  input  pipe_pkg::wmask_t i_wmask,
  input  pipe_pkg::word_t  i_wdata,
  output logic             o_addr_ok,
  output pipe_pkg::word_t  o_rdata
);
  import pipe_pkg::*;

  word_t                  mem [SRAM_DEPTH];
  logic [SRAM_IDX_WD-1:0] idx;
  logic                   wr_recover;   // one dead cycle after a write
  logic                   wr_acc;
  logic                   rd_acc;

  assign idx       = i_addr[SRAM_IDX_LSB +: SRAM_IDX_WD];
  assign o_addr_ok = !wr_recover;
  assign wr_acc    = i_wen && o_addr_ok;
  assign rd_acc    = i_ren && o_addr_ok;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      wr_recover <= 1'b0;
    end else begin
      wr_recover <= wr_acc;
    end
  end

  // byte masked write
  always_ff @(posedge i_clk) begin
    if (wr_acc) begin
      for (int b = 0; b < WMASK_WD; b++) begin
        if (i_wmask[b]) begin
          mem[idx][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (rd_acc) begin
      o_rdata <= mem[idx];   // held until the next accepted read
    end
  end

endmodule

// ==== ex_mem_top.sv ====
// execute and memory stages top
module ex_mem_top (
  input  logic                i_clk,
  input  logic                i_reset,
  // issue
  input  logic                i_issue_valid,
  output logic                o_issue_allowin,
  input  pipe_pkg::alu_op_t   i_issue_op,
  input  logic                i_issue_word_cut,
  input  pipe_pkg::word_t     i_issue_src1,
  input  pipe_pkg::word_t     i_issue_src2,
  input  pipe_pkg::word_t     i_issue_store_data,
  input  pipe_pkg::gpr_addr_t i_issue_rd,
  input  logic                i_issue_gpr_wen,
  input  logic                i_issue_mem_ren,
  input  logic                i_issue_mem_wen,
  input  pipe_pkg::mem_op_t   i_issue_mem_op,
  // write back
  input  logic                i_wb_allowin,
  output logic                o_wb_valid,
  output pipe_pkg::gpr_addr_t o_wb_rd,
  output logic                o_wb_gpr_wen,
  output pipe_pkg::word_t     o_wb_data
);
  import pipe_pkg::*;

  // es -> ms
  logic      es_to_ms_valid;
  logic      ms_allowin;
  gpr_addr_t ms_rd;
  logic      ms_gpr_wen;
  logic      ms_mem_ren;
  mem_op_t   ms_mem_op;
  word_t     ms_alu_result;
  // data sram
  addr_t     sram_addr;
  logic      sram_ren;
  logic      sram_wen;
  wmask_t    sram_wmask;
  word_t     sram_wdata;
  logic      sram_addr_ok;
  word_t     sram_rdata;

  ex_stage u_ex_stage (
    .i_clk              (i_clk),
    .i_reset            (i_reset),
    .i_issue_valid      (i_issue_valid),
    .o_issue_allowin    (o_issue_allowin),
    .i_issue_op         (i_issue_op),
    .i_issue_word_cut   (i_issue_word_cut),
    .i_issue_src1       (i_issue_src1),
    .i_issue_src2       (i_issue_src2),
    .i_issue_store_data (i_issue_store_data),
    .i_issue_rd         (i_issue_rd),
    .i_issue_gpr_wen    (i_issue_gpr_wen),
    .i_issue_mem_ren    (i_issue_mem_ren),
    .i_issue_mem_wen    (i_issue_mem_wen),
    .i_issue_mem_op     (i_issue_mem_op),
    .i_ms_allowin       (ms_allowin),
    .o_es_to_ms_valid   (es_to_ms_valid),
    .o_ms_rd            (ms_rd),
    .o_ms_gpr_wen       (ms_gpr_wen),
    .o_ms_mem_ren       (ms_mem_ren),
    .o_ms_mem_op        (ms_mem_op),
    .o_ms_alu_result    (ms_alu_result),
    .o_sram_addr        (sram_addr),
    .o_sram_ren         (sram_ren),
    .o_sram_wen         (sram_wen),
    .o_sram_wmask       (sram_wmask),
    .o_sram_wdata       (sram_wdata),
    .i_sram_addr_ok     (sram_addr_ok)
  );

  mem_stage u_mem_stage (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_es_to_ms_valid (es_to_ms_valid),
    .o_ms_allowin     (ms_allowin),
    .i_ms_rd          (ms_rd),
    .i_ms_gpr_wen     (ms_gpr_wen),
    .i_ms_mem_ren     (ms_mem_ren),
    .i_ms_mem_op      (ms_mem_op),
    .i_ms_alu_result  (ms_alu_result),
    .i_sram_rdata     (sram_rdata),
    .i_wb_allowin     (i_wb_allowin),
    .o_wb_valid       (o_wb_valid),
    .o_wb_rd          (o_wb_rd),
    .o_wb_gpr_wen     (o_wb_gpr_wen),
    .o_wb_data        (o_wb_data)
  );

  data_sram u_data_sram (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_addr    (sram_addr),
    .i_ren     (sram_ren),
    .i_wen     (sram_wen),
    .i_wmask   (sram_wmask),
    .i_wdata   (sram_wdata),
    .o_addr_ok (sram_addr_ok),
    .o_rdata   (sram_rdata)
  );

endmodule

// ==== tb_clock.sv ====
// testbench clock source
module tb_clock (
  output logic o_clk
);

  localparam int HALF_PERIOD = 20;   // 40 unit period

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

endmodule

// ==== tb_ex_mem_assert.sv ====
// ex/mem handshake assertions
module tb_ex_mem_assert (
  input logic         i_clk,
  input logic         i_reset,
  input logic         i_issue_valid,
  input logic         i_issue_allowin,
  input logic [207:0] i_issue_fields,
  input logic         i_wb_valid,
  input logic         i_wb_allowin,
  input logic [63:0]  i_wb_data,
  input logic         i_sram_ren,
  input logic         i_sram_wen
);

  // a stalled instruction must not move
  a_issue_hold: assert property (@(posedge i_clk) disable iff (i_reset)
    i_issue_valid && !i_issue_allowin |=> i_issue_valid && $stable(i_issue_fields))
    else $error("issue fields changed while the issue was stalled");

  a_wb_hold: assert property (@(posedge i_clk) disable iff (i_reset)
    i_wb_valid && !i_wb_allowin |=> i_wb_valid && $stable(i_wb_data))
    else $error("write-back beat changed while held");

  a_sram_rw: assert property (@(posedge i_clk) disable iff (i_reset)
    !(i_sram_ren && i_sram_wen))
    else $error("sram read and write requested together");

endmodule

bind ex_mem_top tb_ex_mem_assert u_tb_ex_mem_assert (
  .i_clk           (i_clk),
  .i_reset         (i_reset),
  .i_issue_valid   (i_issue_valid),
  .i_issue_allowin (o_issue_allowin),
  .i_issue_fields  ({i_issue_op, i_issue_word_cut, i_issue_src1, i_issue_src2,
                     i_issue_store_data, i_issue_rd, i_issue_gpr_wen,
                     i_issue_mem_ren, i_issue_mem_wen, i_issue_mem_op}),
  .i_wb_valid      (o_wb_valid),
  .i_wb_allowin    (i_wb_allowin),
  .i_wb_data       (o_wb_data),
  .i_sram_ren      (sram_ren),
  .i_sram_wen      (sram_wen)
);

// ==== tb_ex_mem.sv ====
// ex/mem pipeline testbench
module tb_ex_mem;
  import pipe_pkg::*;

  localparam int TIMEOUT      = 200;
  localparam int REGION_WORDS = 32;   // loads stay inside prefilled words

  logic      i_clk;
  logic      i_reset;
  logic      i_issue_valid;
  logic      o_issue_allowin;
  alu_op_t   i_issue_op;
  logic      i_issue_word_cut;
  word_t     i_issue_src1;
  word_t     i_issue_src2;
  word_t     i_issue_store_data;
  gpr_addr_t i_issue_rd;
  logic      i_issue_gpr_wen;
  logic      i_issue_mem_ren;
  logic      i_issue_mem_wen;
  mem_op_t   i_issue_mem_op;
  logic      i_wb_allowin;
  logic      o_wb_valid;
  gpr_addr_t o_wb_rd;
  logic      o_wb_gpr_wen;
  word_t     o_wb_data;

  logic [7:0] shadow [2048];   // byte image of the sram, addr[10:0]
  gpr_addr_t  exp_rd [$];
  logic       exp_wen [$];
  word_t      exp_data [$];
  logic       bp_on;

  tb_clock u_tb_clock (.o_clk(i_clk));
  ex_mem_top u_ex_mem_top (.*);

  task automatic stop_fail(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_eq(input string name, input word_t exp, input word_t got);
    if (got !== exp) begin
      stop_fail($sformatf("ERROR t=%0t %s expected %h got %h", $time, name, exp, got));
    end
  endtask

  function automatic word_t rand64();
    return {$urandom, $urandom};
  endfunction

  // random byte offset aligned to the access size
  function automatic word_t rand_off(input mem_op_t m);
    int sz;
    sz = 1 << m[1:0];
    return $urandom_range(7) & ~(sz - 1);
  endfunction

  // expected write-back data, stores also update the shadow image
  function automatic word_t ref_result(input alu_op_t op, input logic wc, input word_t s1,
      input word_t s2, input word_t sd, input logic ren, input logic wen, input mem_op_t mop);
    word_t       r;
    word_t       ld;
    logic [31:0] a32;
    int          sh;
    int          nbytes;
    a32    = s1[31:0];
    sh     = wc ? s2[4:0] : s2[5:0];
    nbytes = 1 << mop[1:0];
    case (op)
      alu_add:  r = s1 + s2;
      alu_sub:  r = s1 - s2;
      alu_sll:  r = wc ? {32'b0, a32 << sh} : s1 << sh;
      alu_srl:  r = wc ? {32'b0, a32 >> sh} : s1 >> sh;
      alu_sra: begin
        if (wc) r = {32'b0, $signed(a32) >>> sh};
        else r = $signed(s1) >>> sh;
      end
      alu_slt:  r = ($signed(s1) < $signed(s2)) ? 64'd1 : 64'd0;
      alu_sltu: r = (s1 < s2) ? 64'd1 : 64'd0;
      alu_and:  r = s1 & s2;
      alu_or:   r = s1 | s2;
      alu_xor:  r = s1 ^ s2;
      default:  r = s2;
    endcase
    if (wc) r = {{32{r[31]}}, r[31:0]};
    if (wen) begin
      for (int b = 0; b < nbytes; b++) shadow[r[10:0] + b] = sd[b*8 +: 8];
    end
    if (!ren) return r;
    ld = '0;
    for (int b = 0; b < nbytes; b++) ld[b*8 +: 8] = shadow[r[10:0] + b];
    if (!mop[2] && nbytes == 1) ld = {{56{ld[7]}}, ld[7:0]};
    if (!mop[2] && nbytes == 2) ld = {{48{ld[15]}}, ld[15:0]};
    if (!mop[2] && nbytes == 4) ld = {{32{ld[31]}}, ld[31:0]};
    return ld;
  endfunction

  task automatic issue(input alu_op_t op, input logic wc, input word_t s1, input word_t s2,
      input word_t sd, input gpr_addr_t rd, input logic gwen, input logic ren,
      input logic wen, input mem_op_t mop);
    int waited;
    waited             = 0;
    i_issue_valid      = 1'b1;
    i_issue_op         = op;
    i_issue_word_cut   = wc;
    i_issue_src1       = s1;
    i_issue_src2       = s2;
    i_issue_store_data = sd;
    i_issue_rd         = rd;
    i_issue_gpr_wen    = gwen;
    i_issue_mem_ren    = ren;
    i_issue_mem_wen    = wen;
    i_issue_mem_op     = mop;
    exp_data.push_back(ref_result(op, wc, s1, s2, sd, ren, wen, mop));
    exp_rd.push_back(rd);
    exp_wen.push_back(gwen);
    @(negedge i_clk);
    while (!o_issue_allowin) begin
      waited++;
      if (waited > TIMEOUT) stop_fail("timeout waiting for the DUT to accept an issue");
      @(negedge i_clk);
    end
    @(posedge i_clk);
    #2;
    i_issue_valid = 1'b0;
  endtask

  // address goes through the alu as src1 + src2
  task automatic mem_access(input logic ren, input logic wen, input mem_op_t mop,
      input word_t addr, input word_t data);
    word_t s1;
    s1 = rand64();
    issue(alu_add, 1'b0, s1, addr - s1, data, gpr_addr_t'($urandom_range(31)), ren, ren,
          wen, mop);
  endtask

  task automatic drive_backpressure();
    forever begin
      @(posedge i_clk);
      #2;
      i_wb_allowin = bp_on ? ($urandom_range(99) >= 40) : 1'b1;   // ~40% stall
    end
  endtask

  // a beat is taken at the next edge
  always @(negedge i_clk) begin
    if (!i_reset && o_wb_valid && i_wb_allowin) begin
      if (exp_data.size() == 0) stop_fail("write-back beat with no instruction outstanding");
      check_eq("o_wb_rd", exp_rd.pop_front(), o_wb_rd);
      check_eq("o_wb_gpr_wen", exp_wen.pop_front(), o_wb_gpr_wen);
      check_eq("o_wb_data", exp_data.pop_front(), o_wb_data);
    end
  end

  initial begin
    word_t   addr;
    mem_op_t mop;
    int      waited;
    void'($urandom(4504));
    bp_on              = 1'b0;
    i_reset            = 1'b1;
    i_issue_valid      = 1'b0;
    i_issue_op         = alu_add;
    i_issue_word_cut   = 1'b0;
    i_issue_src1       = '0;
    i_issue_src2       = '0;
    i_issue_store_data = '0;
    i_issue_rd         = '0;
    i_issue_gpr_wen    = 1'b0;
    i_issue_mem_ren    = 1'b0;
    i_issue_mem_wen    = 1'b0;
    i_issue_mem_op     = mem_d;
    i_wb_allowin       = 1'b1;
    fork
      drive_backpressure();
    join_none
    for (int c = 1; c <= 10; c++) begin
      @(posedge i_clk);
      #2;
      if (c == 10) i_reset = 1'b0;
      @(negedge i_clk);
      check_eq("o_wb_valid", 64'd0, o_wb_valid);
      check_eq("o_issue_allowin", 64'd1, o_issue_allowin);
    end
    @(posedge i_clk);
    #2;
    for (int wc = 0; wc < 2; wc++) begin
      for (int k = 0; k <= 10; k++) begin
        repeat (6) issue(alu_op_t'(k), wc[0], rand64(), rand64(), '0,
                         gpr_addr_t'($urandom_range(31)), 1'b1, 1'b0, 1'b0, mem_d);
      end
    end
    for (int w = 0; w < REGION_WORDS; w++) mem_access(1'b0, 1'b1, mem_d, w * 8, rand64());
    for (int k = 0; k < 16; k++) begin
      addr = $urandom_range(REGION_WORDS - 1) * 8;
      mop  = mem_op_t'(k % 4);
      mem_access(1'b0, 1'b1, mop, addr + rand_off(mop), rand64());
      for (int m = 0; m < 7; m++) begin
        mem_access(1'b1, 1'b0, mem_op_t'(m), addr + rand_off(mem_op_t'(m)), '0);
      end
    end
    // load right behind a store hits write recovery
    repeat (12) begin
      mop  = mem_op_t'($urandom_range(3));
      addr = $urandom_range(REGION_WORDS - 1) * 8 + rand_off(mop);
      mem_access(1'b0, 1'b1, mop, addr, rand64());
      mem_access(1'b1, 1'b0, mop, addr, '0);
    end
    bp_on = 1'b1;
    repeat (300) begin
      mop  = mem_op_t'($urandom_range(6));
      addr = $urandom_range(REGION_WORDS - 1) * 8 + rand_off(mop);
      case ($urandom_range(4))
        3:       mem_access(1'b0, 1'b1, mop, addr, rand64());
        4:       mem_access(1'b1, 1'b0, mop, addr, '0);
        default: issue(alu_op_t'($urandom_range(10)), 1'($urandom_range(1)), rand64(),
                       rand64(), '0, gpr_addr_t'($urandom_range(31)), 1'b1, 1'b0, 1'b0,
                       mem_d);
      endcase
    end
    waited = 0;
    while (exp_data.size() != 0) begin
      waited++;
      if (waited > TIMEOUT) stop_fail("timeout waiting for the last write-back beats");
      @(negedge i_clk);
    end
    bp_on = 1'b0;
    repeat (5) @(negedge i_clk);   // catch stray beats
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== project.f ====
pipe_pkg.sv
ex_alu.sv
ex_store_align.sv
ex_stage.sv
mem_stage.sv
data_sram.sv
ex_mem_top.sv
tb_clock.sv
tb_ex_mem_assert.sv
tb_ex_mem.sv
